// ==== verilog/rr_defs.svh ====
`ifndef RR_DEFS_SVH
`define RR_DEFS_SVH

// ************************************************************
// Merge unit sizes
// ************************************************************

// Byte width.
`define RR_DATA_W 8

// Input ports served in turn.
`define RR_PORTS 4

// Entries per queue; pointer wraps on its own at this depth.
`define RR_DEPTH 8
`define RR_PTR_W 3

`endif

// ==== verilog/rr_pkg.sv ====
`include "rr_defs.svh"

package rr_pkg;

    // ************************************************************
    // Data path and control types
    // ************************************************************

    typedef logic [`RR_DATA_W-1:0] rr_data_t;

    typedef logic [$clog2(`RR_PORTS)-1:0] rr_port_t;  // Port index.

    // Holds 0 to RR_DEPTH, one bit wider than a pointer.
    typedef logic [`RR_PTR_W:0] rr_count_t;

    typedef enum logic {
        RR_IDLE  = 1'b0,  // All queues empty.
        RR_SERVE = 1'b1   // Slots stepping.
    } rr_state_t;

endpackage

// ==== verilog/rr_queue.sv ====
`timescale 1ns/1ns
`include "rr_defs.svh"

module rr_queue (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wen,
    input  logic             ren,
    input  rr_pkg::rr_data_t din,
    output rr_pkg::rr_data_t q_dout,
    output logic             not_empty,
    output logic             overflow
);

    import rr_pkg::*;

    rr_data_t              mem [0:`RR_DEPTH-1];
    logic [`RR_PTR_W-1:0]  head;
    logic [`RR_PTR_W-1:0]  tail;
    rr_count_t             count;
    logic                  full;
    logic                  do_wr;
    logic                  do_rd;

    assign full      = (count == rr_count_t'(`RR_DEPTH));
    assign not_empty = (count != '0);
    assign do_wr     = wen && !full;      // Full queue drops the byte.
    assign do_rd     = ren && not_empty;

    // ************************************************************
    // Storage
    // ************************************************************

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[tail] <= din;
        end
    end

    // ************************************************************
    // Pointers and fill level
    // ************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                tail <= tail + 1'b1;      // Wraps at depth.
            end
            if (do_rd) begin
                head <= head + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head byte out for one cycle per read, zero otherwise.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_dout   <= '0;
            overflow <= 1'b0;
        end else begin
            q_dout   <= do_rd ? mem[head] : '0;
            overflow <= wen && full;      // One-cycle pulse.
        end
    end

endmodule

// ==== verilog/rr_slot_counter.sv ====
`timescale 1ns/1ns

module rr_slot_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             count_en,
    output rr_pkg::rr_port_t slot
);

    import rr_pkg::*;

    rr_port_t slot_next;

    // Service order 0, 1, 2, 3 by natural wrap.
    assign slot_next = slot + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (count_en) begin
            slot <= slot_next;
        end
    end

endmodule

// ==== verilog/rr_grant_fsm.sv ====
`timescale 1ns/1ns
`include "rr_defs.svh"

module rr_grant_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`RR_PORTS-1:0] wen,
    input  logic [`RR_PORTS-1:0] not_empty,
    input  rr_pkg::rr_port_t     slot,
    output logic [`RR_PORTS-1:0] ren,
    output logic                 count_en,
    output logic                 rd_fire,
    output rr_pkg::rr_port_t     rd_port
);

    import rr_pkg::*;

    rr_state_t state;
    rr_state_t state_next;
    logic      grant;

    // Slot's queue is read only if it has data and no write is under way.
    assign grant    = (state == RR_SERVE) && not_empty[slot] && !wen[slot];
    assign count_en = (state == RR_SERVE);

    always_comb begin
        ren       = '0;
        ren[slot] = grant;
    end

    // ************************************************************
    // State machine
    // ************************************************************

    always_comb begin
        state_next = state;
        case (state)
            RR_IDLE: begin
                if (|not_empty) begin
                    state_next = RR_SERVE;
                end
            end
            RR_SERVE: begin
                if (!(|not_empty) && !grant) begin
                    state_next = RR_IDLE;
                end
            end
            default: state_next = RR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= RR_IDLE;
            rd_fire <= 1'b0;
            rd_port <= '0;
        end else begin
            state   <= state_next;
            rd_fire <= grant;             // Lines up with q_dout.
            if (grant) begin
                rd_port <= slot;
            end
        end
    end

endmodule

// ==== verilog/rr_merge.sv ====
`timescale 1ns/1ns

module rr_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  rr_pkg::rr_data_t q_dout_a,
    input  rr_pkg::rr_data_t q_dout_b,
    input  rr_pkg::rr_data_t q_dout_c,
    input  rr_pkg::rr_data_t q_dout_d,
    input  logic             rd_fire,
    input  rr_pkg::rr_port_t rd_port,
    output rr_pkg::rr_data_t dout,
    output logic             valid,
    output rr_pkg::rr_port_t src
);

    import rr_pkg::*;

    rr_data_t or_all;

    // Idle queues drive zero, so the OR picks the one being read.
    assign or_all = q_dout_a | q_dout_b | q_dout_c | q_dout_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout  <= '0;
            valid <= 1'b0;
            src   <= '0;
        end else begin
            dout  <= or_all;
            valid <= rd_fire;
            src   <= rd_port;
        end
    end

endmodule

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ns
`include "rr_defs.svh"

module rr_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`RR_PORTS-1:0] wen,
    input  rr_pkg::rr_data_t     din_a,
    input  rr_pkg::rr_data_t     din_b,
    input  rr_pkg::rr_data_t     din_c,
    input  rr_pkg::rr_data_t     din_d,
    output rr_pkg::rr_data_t     dout,
    output logic                 valid,
    output rr_pkg::rr_port_t     src,
    output logic [`RR_PORTS-1:0] overflow
);

    import rr_pkg::*;

    rr_data_t             q_dout_a;
    rr_data_t             q_dout_b;
    rr_data_t             q_dout_c;
    rr_data_t             q_dout_d;
    logic [`RR_PORTS-1:0] not_empty;
    logic [`RR_PORTS-1:0] ren;
    logic                 count_en;
    logic                 rd_fire;
    rr_port_t             rd_port;
    rr_port_t             slot;

    // ************************************************************
    // Per-port queues
    // ************************************************************

    rr_queue u_queue_a (
        .clk(clk), .rst_n(rst_n), .wen(wen[0]), .ren(ren[0]), .din(din_a),
        .q_dout(q_dout_a), .not_empty(not_empty[0]), .overflow(overflow[0])
    );

    rr_queue u_queue_b (
        .clk(clk), .rst_n(rst_n), .wen(wen[1]), .ren(ren[1]), .din(din_b),
        .q_dout(q_dout_b), .not_empty(not_empty[1]), .overflow(overflow[1])
    );

    rr_queue u_queue_c (
        .clk(clk), .rst_n(rst_n), .wen(wen[2]), .ren(ren[2]), .din(din_c),
        .q_dout(q_dout_c), .not_empty(not_empty[2]), .overflow(overflow[2])
    );

    rr_queue u_queue_d (
        .clk(clk), .rst_n(rst_n), .wen(wen[3]), .ren(ren[3]), .din(din_d),
        .q_dout(q_dout_d), .not_empty(not_empty[3]), .overflow(overflow[3])
    );

    // ************************************************************
    // Arbitration and output
    // ************************************************************

    rr_slot_counter u_slot_counter (
        .clk(clk), .rst_n(rst_n), .count_en(count_en), .slot(slot)
    );

    rr_grant_fsm u_grant_fsm (
        .clk(clk), .rst_n(rst_n), .wen(wen), .not_empty(not_empty), .slot(slot),
        .ren(ren), .count_en(count_en), .rd_fire(rd_fire), .rd_port(rd_port)
    );

    rr_merge u_merge (
        .clk(clk), .rst_n(rst_n),
        .q_dout_a(q_dout_a), .q_dout_b(q_dout_b),
        .q_dout_c(q_dout_c), .q_dout_d(q_dout_d),
        .rd_fire(rd_fire), .rd_port(rd_port),
        .dout(dout), .valid(valid), .src(src)
    );

endmodule

// ==== bench/rr_arbiter_tb.sv ====
`timescale 1ns/1ns
`include "rr_defs.svh"

module rr_arbiter_tb;

    import rr_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic [`RR_PORTS-1:0] wen;
    rr_data_t             din_a;
    rr_data_t             din_b;
    rr_data_t             din_c;
    rr_data_t             din_d;
    rr_data_t             dout;
    logic                 valid;
    rr_port_t             src;
    logic [`RR_PORTS-1:0] overflow;

    rr_data_t    model_q [0:`RR_PORTS-1][$];  // Written, not yet seen at dout.
    rr_port_t    src_log [$];
    logic [31:0] lcg_state;
    int          ovf_b_count;

    rr_arbiter u_rr_arbiter (
        .clk(clk), .rst_n(rst_n), .wen(wen),
        .din_a(din_a), .din_b(din_b), .din_c(din_c), .din_d(din_d),
        .dout(dout), .valid(valid), .src(src), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ************************************************************
    // Reference model and checks
    // ************************************************************

    // Pop for this cycle's output first, then take the writes of the same edge.
    function automatic logic [`RR_PORTS-1:0] ref_model(
        input  logic                              v,
        input  rr_port_t                          s,
        input  logic [`RR_PORTS-1:0]              w,
        input  logic [`RR_PORTS*`RR_DATA_W-1:0]   d_all,
        output rr_data_t                          exp_byte,
        output logic                              missing
    );
        logic [`RR_PORTS-1:0] ovf;
        int                   p;
        ovf      = '0;
        exp_byte = '0;
        missing  = 1'b0;
        if (v) begin
            if (model_q[s].size() == 0) begin
                missing = 1'b1;
            end else begin
                exp_byte = model_q[s].pop_front();
            end
        end
        for (p = 0; p < `RR_PORTS; p++) begin
            if (w[p] && model_q[p].size() == `RR_DEPTH) begin
                ovf[p] = 1'b1;                 // Byte is dropped.
            end else if (w[p]) begin
                model_q[p].push_back(d_all[p*`RR_DATA_W +: `RR_DATA_W]);
            end
        end
        return ovf;
    endfunction

    function automatic logic model_empty();
        int   p;
        logic empty;
        empty = 1'b1;
        for (p = 0; p < `RR_PORTS; p++) begin
            if (model_q[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic rr_data_t rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[31:24];                       // Upper bits are the better ones.
    endfunction

    task automatic stop_run(input string why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input rr_data_t exp, input rr_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            stop_run("output value mismatch");
        end
    endtask

    task automatic check_port(input string name, input rr_port_t exp, input rr_port_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            stop_run("output value mismatch");
        end
    endtask

    task automatic check_flags(input string name, input logic [`RR_PORTS-1:0] exp,
                               input logic [`RR_PORTS-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h got %h", name, exp, act);
            stop_run("output value mismatch");
        end
    endtask

    initial begin : monitor
        rr_data_t             exp_byte;
        logic                 missing;
        logic [`RR_PORTS-1:0] exp_ovf;
        forever begin
            @(posedge clk);
            #1;                                // Outputs settled, inputs unchanged.
            if (rst_n) begin
                exp_ovf = ref_model(valid, src, wen, {din_d, din_c, din_b, din_a},
                                    exp_byte, missing);
                if (missing) begin
                    stop_run("valid output with no byte left for that port");
                end
                if (valid) begin
                    check_data("dout", exp_byte, dout);
                    src_log.push_back(src);
                end
                check_flags("overflow", exp_ovf, overflow);
                if (overflow[1]) begin
                    ovf_b_count++;
                end
            end
        end
    end

    // ************************************************************
    // Stimulus
    // ************************************************************

    task automatic drive_cycle(input logic [`RR_PORTS-1:0] w, input rr_data_t a,
                               input rr_data_t b, input rr_data_t c, input rr_data_t d);
        @(negedge clk);
        wen   = w;
        din_a = a;
        din_b = b;
        din_c = c;
        din_d = d;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle('0, '0, '0, '0, '0);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (!model_empty() && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!model_empty()) begin
            stop_run("timeout waiting for the queues to drain");
        end
        idle_cycles(4);                        // Room for a stray extra byte.
    endtask

    task automatic check_idle_after_reset();
        int i;
        for (i = 0; i < 10; i++) begin
            idle_cycles(1);
            check_data("dout", '0, dout);      // Reset values with no reads.
            check_port("src", '0, src);
        end
    endtask

    task automatic burst_port_a();
        int i;
        src_log.delete();
        for (i = 0; i < 6; i++) begin
            drive_cycle(4'b0001, rand_byte(), '0, '0, '0);
        end
        idle_cycles(1);
        wait_drain(100);
        if (src_log.size() != 6) begin
            stop_run("port a burst did not return six bytes");
        end
        for (i = 0; i < src_log.size(); i++) begin
            check_port("src", 2'd0, src_log[i]);
        end
    endtask

    task automatic load_all_and_drain();
        int       i;
        rr_port_t exp_src;
        src_log.delete();
        for (i = 0; i < 4; i++) begin
            drive_cycle(4'b1111, rand_byte(), rand_byte(), rand_byte(), rand_byte());
        end
        idle_cycles(1);
        wait_drain(100);
        if (src_log.size() != 16) begin
            stop_run("full load did not return sixteen bytes");
        end
        for (i = 1; i < src_log.size(); i++) begin
            exp_src = src_log[i-1] + 1'b1;     // Wraps 3 to 0.
            check_port("src", exp_src, src_log[i]);
        end
    endtask

    task automatic write_c_while_serving();
        int i;
        int c_seen;
        for (i = 0; i < 3; i++) begin
            drive_cycle(4'b1011, rand_byte(), rand_byte(), '0, rand_byte());
        end
        src_log.delete();
        for (i = 0; i < 6; i++) begin
            drive_cycle(4'b0100, '0, '0, rand_byte(), '0);
        end
        idle_cycles(2);                        // Reads up to the last c write seen.
        for (i = 0; i < src_log.size(); i++) begin
            if (src_log[i] == 2'd2) begin
                stop_run("port c was read while it was being written");
            end
        end
        wait_drain(100);
        c_seen = 0;
        for (i = 0; i < src_log.size(); i++) begin
            if (src_log[i] == 2'd2) begin
                c_seen++;
            end
        end
        if (c_seen != 6) begin
            stop_run("port c did not return all six bytes");
        end
    endtask

    task automatic overflow_port_b();
        int i;
        ovf_b_count = 0;
        src_log.delete();
        for (i = 0; i < 9; i++) begin
            drive_cycle(4'b0010, '0, rand_byte(), '0, '0);
        end
        idle_cycles(1);
        wait_drain(100);
        if (ovf_b_count != 1) begin
            stop_run("overflow on port b did not pulse exactly once");
        end
        if (src_log.size() != 8) begin
            stop_run("port b did not return exactly eight bytes");
        end
    endtask

    task automatic random_mix();
        int                   n;
        int                   p;
        logic [31:0]          r;
        logic [`RR_PORTS-1:0] w;
        for (n = 0; n < 200; n++) begin
            r = next_rand();
            for (p = 0; p < `RR_PORTS; p++) begin
                w[p] = (r[20 + 3*p +: 3] < 3'd2);  // About one write in four.
            end
            drive_cycle(w, rand_byte(), rand_byte(), rand_byte(), rand_byte());
        end
        idle_cycles(1);
        wait_drain(300);
    endtask

    initial begin : stimulus
        rst_n       = 1'b0;
        wen         = '0;
        din_a       = '0;
        din_b       = '0;
        din_c       = '0;
        din_d       = '0;
        lcg_state   = 32'd64947;
        ovf_b_count = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_idle_after_reset();
        burst_port_a();
        load_all_and_drain();
        write_c_while_serving();
        overflow_port_b();
        random_mix();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/rr_pkg.sv
verilog/rr_queue.sv
verilog/rr_slot_counter.sv
verilog/rr_grant_fsm.sv
verilog/rr_merge.sv
verilog/rr_arbiter.sv
bench/rr_arbiter_tb.sv

// ==== Makefile ====
# Verilator build for the round-robin merge unit.

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= rr_arbiter_tb
DUT_TOP   ?= rr_arbiter
FLAGS     ?= -sv
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

# The binary exits non-zero when the testbench stops on $fatal.
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
